// ==== source/dmac_pkg.sv ====
package dmac_pkg;

  // ####################################################################
  // Sizes
  // ####################################################################

  localparam int data_width = 64;
  localparam int max_beats_per_burst = 16;
  localparam int burst_len_width = 4;     // Beats minus one.
  localparam int xfer_len_width = 16;     // Beats minus one.
  localparam int id_width = 3;

  // Queue depth in the mover, also the splitter's starting credit.
  localparam int burst_fifo_depth = 2;
  localparam int burst_fifo_ptr_width = $clog2(burst_fifo_depth);
  localparam int burst_fifo_count_width = $clog2(burst_fifo_depth + 1);

  // ####################################################################
  // Types
  // ####################################################################

  typedef enum logic [1:0] {
    reg_ctrl     = 2'd0,
    reg_xfer_len = 2'd1,
    reg_start    = 2'd2,
    reg_status   = 2'd3
  } reg_addr_e;

  typedef enum logic {
    split_idle,
    split_issue
  } split_state_e;

  typedef struct packed {
    logic [burst_len_width-1:0] len;    // Beats minus one.
    logic                       eot;    // Last burst of the transfer.
  } burst_req_t;

endpackage

// ==== source/dmac_burst_if.sv ====
`timescale 1ns/1ps

interface dmac_burst_if;

  import dmac_pkg::*;

  logic       req_valid;
  burst_req_t req;
  logic       credit_return;    // One pulse per finished burst.
  logic       enabled;

  modport splitter (
    output req_valid,
    output req,
    input  credit_return,
    input  enabled
  );

  modport mover (
    input  req_valid,
    input  req,
    output credit_return,
    output enabled
  );

endinterface

// ==== source/dmac_regs.sv ====
`timescale 1ns/1ps

module dmac_regs (
  input  logic                                clk,
  input  logic                                resetn,

  input  logic                                reg_wr_en,
  input  dmac_pkg::reg_addr_e                 reg_addr,
  input  logic [31:0]                         reg_wdata,
  output logic [31:0]                         reg_rdata,

  input  logic                                busy,
  input  logic [15:0]                         burst_done_count,

  output logic                                enable,
  output logic [dmac_pkg::xfer_len_width-1:0] xfer_len,
  output logic                                start_pulse
);

  import dmac_pkg::*;

  logic        busy_q;
  logic [15:0] xfer_done_count;
  logic        start_wr;

  assign start_wr = reg_wr_en && (reg_addr == reg_start);

  // ####################################################################
  // Writable registers
  // ####################################################################

  always_ff @(posedge clk) begin
    if (!resetn) begin
      enable <= 1'b0;
      xfer_len <= '0;
    end else if (reg_wr_en) begin
      case (reg_addr)
        reg_ctrl:     enable <= reg_wdata[0];
        reg_xfer_len: xfer_len <= reg_wdata[xfer_len_width-1:0];
        default:      ;
      endcase
    end
  end

  // Start only goes through when enabled and idle.
  always_ff @(posedge clk) begin
    if (!resetn) begin
      start_pulse <= 1'b0;
    end else begin
      start_pulse <= start_wr && enable && !busy;
    end
  end

  // ####################################################################
  // Status
  // ####################################################################

  always_ff @(posedge clk) begin
    if (!resetn) begin
      busy_q <= 1'b0;
      xfer_done_count <= '0;
    end else begin
      busy_q <= busy;
      if (busy_q && !busy) begin
        xfer_done_count <= xfer_done_count + 16'd1;   // Falling edge of busy.
      end
    end
  end

  // Status bit 0 is busy, so the low count field holds 15 bits of the burst count.
  always_comb begin
    case (reg_addr)
      reg_ctrl:     reg_rdata = {31'd0, enable};
      reg_xfer_len: reg_rdata = {{(32 - xfer_len_width){1'b0}}, xfer_len};
      reg_status:   reg_rdata = {xfer_done_count, burst_done_count[14:0], busy};
      default:      reg_rdata = 32'd0;    // Start is write only.
    endcase
  end

endmodule

// ==== source/dmac_request_splitter.sv ====
`timescale 1ns/1ps

module dmac_request_splitter (
  input  logic                                clk,
  input  logic                                resetn,

  input  logic                                start_pulse,
  input  logic [dmac_pkg::xfer_len_width-1:0] xfer_len,
  output logic                                busy,

  dmac_burst_if.splitter                      burst
);

  import dmac_pkg::*;

  split_state_e                      state;
  logic [xfer_len_width-1:0]         remaining;   // Beats left, minus one.
  logic [burst_fifo_count_width-1:0] credits;
  logic                              final_burst;
  logic                              issue;
  burst_req_t                        next_req;

  assign final_burst = remaining < xfer_len_width'(max_beats_per_burst);

  // One request per cycle while a credit is held.
  assign issue = (state == split_issue) && (credits != '0) && burst.enabled;

  always_comb begin
    next_req.eot = final_burst;
    if (final_burst) begin
      next_req.len = remaining[burst_len_width-1:0];
    end else begin
      next_req.len = burst_len_width'(max_beats_per_burst - 1);
    end
  end

  assign burst.req_valid = issue;
  assign burst.req = next_req;
  assign busy = start_pulse || (state == split_issue);

  // ####################################################################
  // FSM
  // ####################################################################

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= split_idle;
    end else begin
      case (state)
        split_idle: begin
          if (start_pulse) begin
            state <= split_issue;
          end
        end
        split_issue: begin
          if (issue && final_burst) begin
            state <= split_idle;    // Eot burst is out.
          end
        end
        default: state <= split_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_pulse) begin
      remaining <= xfer_len;
    end else if (issue && !final_burst) begin
      remaining <= remaining - xfer_len_width'(max_beats_per_burst);
    end
  end

  // ####################################################################
  // Credits
  // ####################################################################

  always_ff @(posedge clk) begin
    if (!resetn) begin
      credits <= burst_fifo_count_width'(burst_fifo_depth);
    end else begin
      case ({issue, burst.credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: ;    // Spent and returned together.
      endcase
    end
  end

endmodule

// ==== source/dmac_data_mover.sv ====
`timescale 1ns/1ps

module dmac_data_mover (
  input  logic                            clk,
  input  logic                            resetn,

  input  logic                            enable,

  input  logic                            s_valid,
  output logic                            s_ready,
  input  logic [dmac_pkg::data_width-1:0] s_data,

  output logic                            m_valid,
  input  logic                            m_ready,
  output logic [dmac_pkg::data_width-1:0] m_data,
  output logic                            m_last,

  output logic [dmac_pkg::id_width-1:0]   response_id,
  output logic [15:0]                     burst_done_count,

  dmac_burst_if.mover                     burst
);

  import dmac_pkg::*;

  burst_req_t                        queue_mem [burst_fifo_depth];
  logic                              single_mem [burst_fifo_depth];   // One beat burst.
  logic [burst_fifo_ptr_width-1:0]   wr_ptr;
  logic [burst_fifo_ptr_width-1:0]   rd_ptr;
  logic [burst_fifo_count_width-1:0] count;

  burst_req_t                        head;
  logic                              active;
  logic [burst_len_width-1:0]        beat_counter;
  logic [burst_len_width-1:0]        last_index;
  logic                              at_last;
  logic                              beat;
  logic                              burst_end;
  logic [id_width-1:0]               id;

  // ####################################################################
  // Burst queue
  // ####################################################################

  assign head = queue_mem[rd_ptr];
  assign active = count != '0;    // Head of the queue is the active burst.

  always_ff @(posedge clk) begin
    if (burst.req_valid) begin
      queue_mem[wr_ptr] <= burst.req;
      single_mem[wr_ptr] <= burst.req.eot && (burst.req.len == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (burst.req_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (burst_end) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({burst.req_valid, burst_end})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // ####################################################################
  // Beat path
  // ####################################################################

  assign s_ready = m_ready && active;
  assign m_valid = s_valid && active;
  assign m_data = s_data;

  // Only the eot burst can be short.
  assign last_index = head.eot ? head.len : burst_len_width'(max_beats_per_burst - 1);

  assign m_last = active && ((beat_counter == '0) ? single_mem[rd_ptr] : at_last);

  assign beat = m_valid && m_ready;
  assign burst_end = beat && m_last;
  assign burst.credit_return = burst_end;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      beat_counter <= '0;
      at_last <= 1'b0;
    end else if (burst_end) begin
      beat_counter <= '0;
      at_last <= 1'b0;
    end else if (beat) begin
      beat_counter <= beat_counter + 1'b1;
      at_last <= (beat_counter + 1'b1) == last_index;
    end
  end

  // ####################################################################
  // Ids and status
  // ####################################################################

  always_ff @(posedge clk) begin
    if (!resetn) begin
      id <= '0;
      burst_done_count <= '0;
      burst.enabled <= 1'b0;
    end else begin
      burst.enabled <= enable;
      if (burst_end) begin
        id <= id + 1'b1;
        burst_done_count <= burst_done_count + 16'd1;
      end
    end
  end

  assign response_id = id;

endmodule

// ==== source/dmac_top.sv ====
`timescale 1ns/1ps

module dmac_top (
  input  logic                            clk,
  input  logic                            resetn,

  input  logic                            reg_wr_en,
  input  dmac_pkg::reg_addr_e             reg_addr,
  input  logic [31:0]                     reg_wdata,
  output logic [31:0]                     reg_rdata,

  input  logic                            s_valid,
  output logic                            s_ready,
  input  logic [dmac_pkg::data_width-1:0] s_data,

  output logic                            m_valid,
  input  logic                            m_ready,
  output logic [dmac_pkg::data_width-1:0] m_data,
  output logic                            m_last,

  output logic [dmac_pkg::id_width-1:0]   response_id,
  output logic                            enabled
);

  import dmac_pkg::*;

  logic                      enable;
  logic [xfer_len_width-1:0] xfer_len;
  logic                      start_pulse;
  logic                      busy;
  logic [15:0]               burst_done_count;

  dmac_burst_if burst_if0 ();

  assign enabled = burst_if0.enabled;

  dmac_regs regs0 (
    .clk              (clk),
    .resetn           (resetn),
    .reg_wr_en        (reg_wr_en),
    .reg_addr         (reg_addr),
    .reg_wdata        (reg_wdata),
    .reg_rdata        (reg_rdata),
    .busy             (busy),
    .burst_done_count (burst_done_count),
    .enable           (enable),
    .xfer_len         (xfer_len),
    .start_pulse      (start_pulse)
  );

  dmac_request_splitter splitter0 (
    .clk         (clk),
    .resetn      (resetn),
    .start_pulse (start_pulse),
    .xfer_len    (xfer_len),
    .busy        (busy),
    .burst       (burst_if0.splitter)
  );

  dmac_data_mover mover0 (
    .clk              (clk),
    .resetn           (resetn),
    .enable           (enable),
    .s_valid          (s_valid),
    .s_ready          (s_ready),
    .s_data           (s_data),
    .m_valid          (m_valid),
    .m_ready          (m_ready),
    .m_data           (m_data),
    .m_last           (m_last),
    .response_id      (response_id),
    .burst_done_count (burst_done_count),
    .burst            (burst_if0.mover)
  );

endmodule

// ==== tb/dmac_tb_clock.sv ====
`timescale 1ns/1ps

module dmac_tb_clock (
  output logic clk,
  output logic resetn
);

  localparam int half_period = 50;    // 100 ns clock.
  localparam int reset_cycles = 16;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  initial begin
    resetn = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

// ==== tb/dmac_tb.sv ====
`timescale 1ns/1ps

module dmac_tb;

  import dmac_pkg::*;

  localparam int reset_timeout = 64;
  localparam int transfer_timeout = 4000;
  localparam int idle_window = 200;

  logic                  clk;
  logic                  resetn;
  logic                  reg_wr_en;
  reg_addr_e             reg_addr;
  logic [31:0]           reg_wdata;
  logic [31:0]           reg_rdata;
  logic                  s_valid;
  logic                  s_ready;
  logic [data_width-1:0] s_data;
  logic                  m_valid;
  logic                  m_ready;
  logic [data_width-1:0] m_data;
  logic                  m_last;
  logic [id_width-1:0]   response_id;
  logic                  enabled;

  logic [31:0] rng_state;
  int          errors;
  int          tests_passed;
  int          tests_failed;
  int          model_bursts;    // Bursts finished since reset.
  int          model_xfers;

  dmac_tb_clock clock0 (
    .clk    (clk),
    .resetn (resetn)
  );

  dmac_top dut0 (
    .clk         (clk),
    .resetn      (resetn),
    .reg_wr_en   (reg_wr_en),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata),
    .reg_rdata   (reg_rdata),
    .s_valid     (s_valid),
    .s_ready     (s_ready),
    .s_data      (s_data),
    .m_valid     (m_valid),
    .m_ready     (m_ready),
    .m_data      (m_data),
    .m_last      (m_last),
    .response_id (response_id),
    .enabled     (enabled)
  );

  // ####################################################################
  // Helpers
  // ####################################################################

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // Status layout: transfers in 31:16, bursts in 15:1, busy in bit 0.
  function automatic logic [31:0] expected_status();
    return {16'(model_xfers), 15'(model_bursts), 1'b0};
  endfunction

  task automatic check_beat(input string name, input logic [data_width-1:0] exp_data,
                            input logic exp_last, input logic [data_width-1:0] act_data,
                            input logic act_last);
    if (act_data !== exp_data || act_last !== exp_last) begin
      $display("[ERROR] %s: expected %h last %b, actual %h last %b",
               name, exp_data, exp_last, act_data, act_last);
      errors++;
    end
  endtask

  task automatic check_id(input string name, input logic [id_width-1:0] exp_id,
                          input logic [id_width-1:0] act_id);
    if (act_id !== exp_id) begin
      $display("[ERROR] %s: expected id %0d, actual id %0d", name, exp_id, act_id);
      errors++;
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp_value,
                           input logic [31:0] act_value);
    if (act_value !== exp_value) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp_value, act_value);
      errors++;
    end
  endtask

  task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
    @(posedge clk);
    reg_wr_en <= 1'b1;
    reg_addr <= addr;
    reg_wdata <= data;
    @(posedge clk);
    reg_wr_en <= 1'b0;
  endtask

  task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
    @(posedge clk);
    reg_addr <= addr;
    @(negedge clk);
    data = reg_rdata;
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("[PASS] %s", name);
    end else begin
      tests_failed++;
      $display("[FAIL] %s, %0d errors", name, errors - errors_before);
    end
  endtask

  // ####################################################################
  // Transfers
  // ####################################################################

  task automatic run_transfer(input string name, input int len, input bit stall);
    logic [data_width-1:0] src_data [$];
    logic [31:0]           r;
    logic [31:0]           status;
    logic                  exp_last;
    int                    received;
    int                    bursts_seen;
    int                    cycles;
    int                    i;

    for (i = 0; i < len; i++) begin
      src_data.push_back({next_random(), 32'(i)});    // Beat number in the low half.
    end
    write_reg(reg_xfer_len, 32'(len - 1));
    write_reg(reg_start, 32'd1);
    received = 0;
    bursts_seen = 0;
    cycles = 0;
    while (received < len && cycles < transfer_timeout) begin
      @(posedge clk);
      r = next_random();
      s_valid <= !stall || r[1:0] != 2'd0;
      s_data <= src_data[received];
      m_ready <= !stall || r[3:2] != 2'd0;
      @(negedge clk);
      // A beat taken from the source must leave on the destination in the same cycle.
      if ((s_valid && s_ready) !== (m_valid && m_ready)) begin
        $display("%s: source and destination handshakes differ at beat %0d", name, received);
        errors++;
      end
      if (m_valid && m_ready) begin
        exp_last = ((received + 1) % max_beats_per_burst == 0) || (received == len - 1);
        check_id(name, id_width'(model_bursts), response_id);
        check_beat($sformatf("%s beat %0d", name, received), src_data[received],
                   exp_last, m_data, m_last);
        if (exp_last) model_bursts++;
        if (m_last) bursts_seen++;
        received++;
      end
      cycles++;
    end
    @(posedge clk);
    s_valid <= 1'b0;
    m_ready <= 1'b0;
    if (received < len) begin
      $display("Timeout in %s: only %0d of %0d beats arrived", name, received, len);
      errors++;
    end else begin
      model_xfers++;
    end
    check_reg($sformatf("%s bursts", name),
              32'((len + max_beats_per_burst - 1) / max_beats_per_burst), 32'(bursts_seen));
    @(negedge clk);
    check_id(name, id_width'(model_bursts), response_id);
    read_reg(reg_status, status);
    check_reg($sformatf("%s status", name), expected_status(), status);
  endtask

  task automatic check_disabled(input string name);
    logic [31:0] data;
    int          beats;
    int          busy_seen;
    int          cycles;

    write_reg(reg_ctrl, 32'd0);
    write_reg(reg_xfer_len, 32'd7);
    write_reg(reg_start, 32'd1);
    beats = 0;
    busy_seen = 0;
    cycles = 0;
    while (cycles < idle_window) begin    // No beat may show up in this window.
      @(posedge clk);
      reg_addr <= reg_status;
      s_valid <= 1'b1;
      s_data <= {next_random(), next_random()};
      m_ready <= 1'b1;
      @(negedge clk);
      if (m_valid && m_ready) beats++;
      if (reg_rdata[0]) busy_seen++;
      cycles++;
    end
    @(posedge clk);
    s_valid <= 1'b0;
    m_ready <= 1'b0;
    check_reg($sformatf("%s beats", name), 32'd0, 32'(beats));
    check_reg($sformatf("%s busy cycles", name), 32'd0, 32'(busy_seen));
    check_reg($sformatf("%s enabled", name), 32'd0, {31'd0, enabled});
    read_reg(reg_ctrl, data);
    check_reg($sformatf("%s ctrl", name), 32'd0, data);
    read_reg(reg_status, data);
    check_reg($sformatf("%s status", name), expected_status(), data);
  endtask

  // ####################################################################
  // Test sequence
  // ####################################################################

  initial begin
    int          errors_before;
    int          cycles;
    logic [31:0] r;
    logic [31:0] data;

    rng_state = 32'h68b09f37;
    errors = 0;
    tests_passed = 0;
    tests_failed = 0;
    model_bursts = 0;
    model_xfers = 0;
    reg_wr_en = 1'b0;
    reg_addr = reg_ctrl;
    reg_wdata = '0;
    s_valid = 1'b0;
    s_data = '0;
    m_ready = 1'b0;

    cycles = 0;
    while (resetn !== 1'b1 && cycles < reset_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (resetn !== 1'b1) begin
      $display("Timeout: reset was never released");
      errors++;
    end

    errors_before = errors;
    r = next_random();
    write_reg(reg_ctrl, 32'd1);
    write_reg(reg_xfer_len, {16'd0, r[15:0]});
    read_reg(reg_ctrl, data);
    check_reg("reg_readback ctrl", 32'd1, data);
    check_reg("reg_readback enabled", 32'd1, {31'd0, enabled});
    read_reg(reg_xfer_len, data);
    check_reg("reg_readback xfer_len", {16'd0, r[15:0]}, data);
    read_reg(reg_status, data);
    check_reg("reg_readback status", expected_status(), data);
    finish_test("reg_readback", errors_before);

    errors_before = errors;
    r = next_random();
    run_transfer("short_transfer", 1 + int'(r[3:0]), 1'b0);
    finish_test("short_transfer", errors_before);

    errors_before = errors;
    r = next_random();
    run_transfer("long_transfer", 17 + int'(r % 32'd84), 1'b0);    // 17 to 100 beats.
    finish_test("long_transfer", errors_before);

    errors_before = errors;
    r = next_random();
    run_transfer("back_pressure", 1 + int'(r % 32'd100), 1'b1);
    finish_test("back_pressure", errors_before);

    errors_before = errors;
    run_transfer("ids_status", 1, 1'b1);
    run_transfer("ids_status", 16, 1'b1);
    run_transfer("ids_status", 33, 1'b1);
    r = next_random();
    run_transfer("ids_status", 1 + int'(r % 32'd100), 1'b1);
    finish_test("ids_status", errors_before);

    errors_before = errors;
    check_disabled("disable");
    finish_test("disable", errors_before);

    $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== dmac_top.f ====
source/dmac_pkg.sv
source/dmac_burst_if.sv
source/dmac_regs.sv
source/dmac_request_splitter.sv
source/dmac_data_mover.sv
source/dmac_top.sv
tb/dmac_tb_clock.sv
tb/dmac_tb.sv

// ==== Bender.yml ====
package:
  name: dmac

sources:
  - files:
      - source/dmac_pkg.sv
      - source/dmac_burst_if.sv
      - source/dmac_regs.sv
      - source/dmac_request_splitter.sv
      - source/dmac_data_mover.sv
      - source/dmac_top.sv
  - target: test
    files:
      - tb/dmac_tb_clock.sv
      - tb/dmac_tb.sv
